/* hw/mbox_cfg_pkg.sv */
// Sizes and data types shared by the mailbox controller blocks
// Imported by every RTL module and by the testbench

package mbox_cfg_pkg;

    // User attribute carried with every fabric request
    localparam int USER_W = 32;
    typedef logic [USER_W-1:0] user_t;

    // Fabric and SRAM data word
    localparam int DATA_W = 32;
    typedef logic [DATA_W-1:0] data_t;

    // Fabric byte address
    localparam int BUS_ADDR_W = 16;

    // Mailbox SRAM geometry
    localparam int SRAM_SIZE_BYTES = 4096;
    localparam int SRAM_DEPTH      = SRAM_SIZE_BYTES / (DATA_W / 8);
    localparam int SRAM_ADDR_W     = $clog2(SRAM_DEPTH);
    typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;

    // Data length register, in bytes
    localparam int DLEN_W = 32;

    // Valid user list and the user value that always passes
    localparam int    NUM_VALID_USERS = 5;
    localparam user_t DEF_VALID_USER  = '1;

endpackage

/* hw/mbox_reg_pkg.sv */
// Fabric address map of the mailbox
// CSR offsets used as register opcodes, and the SRAM window

package mbox_reg_pkg;

    // CSR byte offsets
    typedef enum logic [mbox_cfg_pkg::BUS_ADDR_W-1:0] {
        REG_LOCK    = 16'h0000,
        REG_USER    = 16'h0004,
        REG_DLEN    = 16'h0008,
        REG_CMD     = 16'h000C,
        REG_EXECUTE = 16'h0010
    } reg_addr_e;

    // SRAM window in the byte map
    // Window is larger than the SRAM, upper offsets fall in a hole
    localparam logic [mbox_cfg_pkg::BUS_ADDR_W-1:0] SRAM_WIN_BASE  = 16'h2000;
    localparam logic [mbox_cfg_pkg::BUS_ADDR_W-1:0] SRAM_WIN_BYTES = 16'h2000;

endpackage

/* hw/mbox_user_check.sv */
// Classifies the user attribute of a fabric request
// Combinational, feeds the access rules of the register block

`timescale 1ns/100ps

module mbox_user_check (
    input  mbox_cfg_pkg::user_t                                     user,
    input  mbox_cfg_pkg::user_t [mbox_cfg_pkg::NUM_VALID_USERS-1:0] valid_users,
    input  mbox_cfg_pkg::user_t                                     strap_root_user,
    input  mbox_cfg_pkg::user_t                                     holder,
    output logic                                                    user_valid,
    output logic                                                    user_is_root,
    output logic                                                    user_is_holder
);

    import mbox_cfg_pkg::*;

    logic list_hit;

    // Any entry of the valid user list
    always_comb begin
        list_hit = 1'b0;
        for (int i = 0; i < NUM_VALID_USERS; i++) begin
            list_hit |= (user == valid_users[i]);
        end
    end

    // Root strap is privileged and always valid
    assign user_is_root = (user == strap_root_user);

    // Owner of the lock, zero after a release
    assign user_is_holder = (user == holder);

    // List, default user or root
    assign user_valid = list_hit | (user == DEF_VALID_USER) | user_is_root;

endmodule

/* hw/mbox_regs.sv */
// Mailbox registers and fabric response
// Lock, holder, length, command and execute, with the access and release rules

`timescale 1ns/100ps

module mbox_regs (
    input  logic                                clk,
    input  logic                                rst_b,
    input  logic                                req,
    input  logic                                write,
    input  logic [mbox_cfg_pkg::BUS_ADDR_W-1:0] addr,
    input  mbox_cfg_pkg::data_t                 wdata,
    input  mbox_cfg_pkg::user_t                 user,
    input  mbox_cfg_pkg::user_t                 strap_root_user,
    input  logic                                user_valid,
    input  logic                                user_is_root,
    input  logic                                user_is_holder,
    input  mbox_cfg_pkg::data_t                 sram_rdata_q,
    input  logic                                sram_rd_ack,
    input  logic                                zero_busy,
    input  logic                                zero_done,
    output mbox_cfg_pkg::data_t                 rdata,
    output logic                                rd_ack,
    output logic                                error,
    output logic                                hold,
    output mbox_cfg_pkg::user_t                 holder,
    output logic                                sram_req,
    output logic                                sram_wr,
    output logic [mbox_cfg_pkg::BUS_ADDR_W-1:0] sram_offset,
    output mbox_cfg_pkg::data_t                 sram_wdata,
    output logic                                mbox_release,
    output logic [mbox_cfg_pkg::SRAM_ADDR_W:0]  zero_words,
    output logic                                soc_req_mbox_locked,
    output logic                                root_data_available,
    output logic                                soc_data_available
);

    import mbox_cfg_pkg::*;
    import mbox_reg_pkg::*;

    reg_addr_e         csr_addr;
    logic              valid_req;
    logic              in_window;
    logic              csr_hit;
    logic              lock_set;
    logic              perm;
    logic              csr_rd;
    logic              csr_wr;
    logic              lock_rd;
    logic              rel_wr;
    logic              root_holds;
    logic              init_q;
    logic              lock_q;
    logic              execute_q;
    logic              csr_ack_q;
    logic [DLEN_W-1:0] dlen_q;
    logic [DLEN_W-1:0] max_dlen_q;
    logic [DLEN_W:0]   dlen_words;
    data_t             cmd_q;
    data_t             csr_rdata;
    data_t             csr_rdata_q;

    ////////////////////////////////////////////////////////////
    // Decode and access rules
    ////////////////////////////////////////////////////////////

    assign csr_addr  = reg_addr_e'(addr);
    assign valid_req = req & user_valid;
    assign in_window = (addr >= SRAM_WIN_BASE) && (addr < SRAM_WIN_BASE + SRAM_WIN_BYTES);

    always_comb begin
        case (csr_addr)
            REG_LOCK, REG_USER, REG_DLEN, REG_CMD, REG_EXECUTE: csr_hit = 1'b1;
            default: csr_hit = 1'b0;
        endcase
    end

    // No owner rights while the SRAM is being cleared or release is pending
    assign lock_set = lock_q & ~zero_busy & ~mbox_release;
    assign perm     = valid_req & lock_set & (user_is_root | user_is_holder);

    // CSR reads are open to any valid user while writes need permission
    assign csr_rd  = valid_req & ~write & csr_hit;
    assign csr_wr  = perm & write & csr_hit;
    assign lock_rd = csr_rd & (csr_addr == REG_LOCK);

    // Clearing a set execute bit hands the mailbox back
    assign rel_wr = csr_wr & (csr_addr == REG_EXECUTE) & ~wdata[0] & execute_q;

    // Unknown user, or neither a register nor the window
    assign error = req & (~user_valid | (~csr_hit & ~in_window));

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            init_q       <= 1'b1;
            lock_q       <= 1'b1;
            holder       <= '0;
            dlen_q       <= '0;
            cmd_q        <= '0;
            execute_q    <= 1'b0;
            mbox_release <= 1'b0;
            csr_ack_q    <= 1'b0;
        end else begin
            init_q       <= 1'b0;
            mbox_release <= rel_wr;
            // Reads not served by the SRAM answer from here
            csr_ack_q    <= req & ~write & ~sram_req;
            // Root owns the mailbox in the first cycle out of reset
            if (init_q) begin
                holder <= strap_root_user;
            end else if (rel_wr) begin
                holder <= '0;
            end else if (lock_rd & ~lock_q) begin
                holder <= user;
            end
            // Lock only drops once zeroization has finished
            if (zero_done) begin
                lock_q <= 1'b0;
            end else if (lock_rd) begin
                lock_q <= 1'b1;
            end
            if (rel_wr) begin
                dlen_q    <= '0;
                cmd_q     <= '0;
                execute_q <= 1'b0;
            end else if (csr_wr) begin
                case (csr_addr)
                    REG_DLEN:    dlen_q    <= wdata;
                    REG_CMD:     cmd_q     <= wdata;
                    REG_EXECUTE: execute_q <= wdata[0];
                    default:     ;
                endcase
            end
        end
    end

    // Largest length of this lock period sizes the clear sweep
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            max_dlen_q <= '0;
        end else if (zero_done) begin
            max_dlen_q <= '0;
        end else if (dlen_q > max_dlen_q) begin
            max_dlen_q <= dlen_q;
        end
    end

    // Bytes to words rounded up and capped at the SRAM depth
    assign dlen_words = ({1'b0, max_dlen_q} + 3'd3) >> 2;
    assign zero_words = (dlen_words > SRAM_DEPTH) ? (SRAM_ADDR_W+1)'(SRAM_DEPTH)
                                                  : dlen_words[SRAM_ADDR_W:0];

    ////////////////////////////////////////////////////////////
    // Fabric response and SRAM request
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (csr_addr)
            REG_LOCK:    csr_rdata = data_t'(lock_q);
            REG_USER:    csr_rdata = holder;
            REG_DLEN:    csr_rdata = dlen_q;
            REG_CMD:     csr_rdata = cmd_q;
            REG_EXECUTE: csr_rdata = data_t'(execute_q);
            default:     csr_rdata = '0;
        endcase
    end

    // LOCK returns the bit as it was before this read
    always_ff @(posedge clk) begin
        csr_rdata_q <= csr_rd ? csr_rdata : '0;
    end

    assign rd_ack = csr_ack_q | sram_rd_ack;
    assign rdata  = sram_rd_ack ? sram_rdata_q : csr_rdata_q;
    assign hold   = valid_req & in_window & ~write;

    // Unpermitted window reads fall back to the zero CSR path
    assign sram_req    = perm & in_window;
    assign sram_wr     = write;
    assign sram_offset = addr - SRAM_WIN_BASE;
    assign sram_wdata  = wdata;

    // Status towards root and SoC
    assign root_holds          = (holder == strap_root_user);
    assign soc_req_mbox_locked = lock_set & root_holds & lock_rd & ~user_is_root;
    assign root_data_available = execute_q & root_holds;
    assign soc_data_available  = execute_q & ~root_holds;

    // A rejected read is answered the next cycle with zero data
    a_error_read_zero: assert property (@(posedge clk) disable iff (!rst_b)
        error && !write |=> rd_ack && (rdata == '0));

endmodule

/* hw/mbox_sram_ctrl.sv */
// SRAM front end of the mailbox window
// Range checks window offsets, forms the SRAM request and returns read data

`timescale 1ns/100ps

module mbox_sram_ctrl (
    input  logic                                clk,
    input  logic                                rst_b,
    input  logic                                sram_req,
    input  logic                                sram_wr,
    input  logic [mbox_cfg_pkg::BUS_ADDR_W-1:0] sram_offset,
    input  mbox_cfg_pkg::data_t                 sram_wdata,
    input  mbox_cfg_pkg::data_t                 sram_rdata,
    output logic                                cs,
    output logic                                we,
    output mbox_cfg_pkg::sram_addr_t            addr,
    output mbox_cfg_pkg::data_t                 wdata,
    output mbox_cfg_pkg::data_t                 sram_rdata_q,
    output logic                                sram_rd_ack
);

    import mbox_cfg_pkg::*;

    logic in_range;
    logic rd_valid_q;

    ////////////////////////////////////////////////////////////
    // Request path
    ////////////////////////////////////////////////////////////

    // Offsets past the memory are dropped
    assign in_range = (sram_offset < SRAM_SIZE_BYTES);

    assign cs    = sram_req & in_range;
    assign we    = cs & sram_wr;
    // Byte offset to word address
    assign addr  = sram_offset[SRAM_ADDR_W+1:2];
    assign wdata = cs ? sram_wdata : '0;

    ////////////////////////////////////////////////////////////
    // Read return
    ////////////////////////////////////////////////////////////

    // Ack every read and remember whether the array was really read
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rd_valid_q  <= 1'b0;
            sram_rd_ack <= 1'b0;
        end else begin
            rd_valid_q  <= cs & ~sram_wr;
            sram_rd_ack <= sram_req & ~sram_wr;
        end
    end

    // SRAM data lands the cycle after cs and dropped reads give zero
    assign sram_rdata_q = rd_valid_q ? sram_rdata : '0;

    // Array returns known data the cycle after a read
    a_rdata_known: assert property (@(posedge clk) disable iff (!rst_b)
        rd_valid_q |-> !$isunknown(sram_rdata));

endmodule

/* hw/mbox_zeroize.sv */
// Clears the used SRAM words after a mailbox release
// Sits in front of the SRAM pins and owns the port while sweeping

`timescale 1ns/100ps

module mbox_zeroize (
    input  logic                               clk,
    input  logic                               rst_b,
    input  logic                               mbox_release,
    input  logic [mbox_cfg_pkg::SRAM_ADDR_W:0] zero_words,
    input  logic                               cs_in,
    input  logic                               we_in,
    input  mbox_cfg_pkg::sram_addr_t           addr_in,
    input  mbox_cfg_pkg::data_t                wdata_in,
    output logic                               sram_cs,
    output logic                               sram_we,
    output mbox_cfg_pkg::sram_addr_t           sram_addr,
    output mbox_cfg_pkg::data_t                sram_wdata,
    output logic                               zero_busy,
    output logic                               zero_done
);

    import mbox_cfg_pkg::*;

    typedef enum logic {
        ZS_IDLE,
        ZS_CLEAR
    } zero_state_e;

    zero_state_e          state_q;
    sram_addr_t           waddr_q;
    logic [SRAM_ADDR_W:0] words_q;
    logic                 clearing;
    logic                 last_word;
    logic                 done_q;

    assign clearing  = (state_q == ZS_CLEAR);
    assign last_word = ({1'b0, waddr_q} == words_q - 1'b1);

    ////////////////////////////////////////////////////////////
    // Sweep FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state_q <= ZS_IDLE;
            waddr_q <= '0;
            words_q <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ZS_IDLE: begin
                    if (mbox_release) begin
                        waddr_q <= '0;
                        words_q <= zero_words;
                        // Empty mailbox finishes the next cycle
                        if (zero_words == '0) begin
                            done_q <= 1'b1;
                        end else begin
                            state_q <= ZS_CLEAR;
                        end
                    end
                end
                ZS_CLEAR: begin
                    // One word per cycle from address zero
                    waddr_q <= waddr_q + 1'b1;
                    if (last_word) begin
                        state_q <= ZS_IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= ZS_IDLE;
            endcase
        end
    end

    // Busy until the lock has dropped
    assign zero_busy = clearing | done_q;
    assign zero_done = done_q;

    // Zero writes while clearing, controller request otherwise
    assign sram_cs    = clearing | cs_in;
    assign sram_we    = clearing | we_in;
    assign sram_addr  = clearing ? waddr_q : addr_in;
    assign sram_wdata = clearing ? '0 : wdata_in;

    // Register block must keep the controller quiet during the sweep
    a_no_cs_while_busy: assert property (@(posedge clk) disable iff (!rst_b)
        zero_busy |-> !cs_in);

endmodule

/* hw/mbox_top.sv */
// Top level of the single SRAM mailbox controller
// Connects the fabric port and SRAM pins to the user check, registers and SRAM path

`timescale 1ns/100ps

module mbox_top (
    input  logic                                                    clk,
    input  logic                                                    rst_b,
    input  logic                                                    req,
    input  logic                                                    write,
    input  logic [mbox_cfg_pkg::BUS_ADDR_W-1:0]                     addr,
    input  mbox_cfg_pkg::data_t                                     wdata,
    input  mbox_cfg_pkg::user_t                                     user,
    input  mbox_cfg_pkg::user_t [mbox_cfg_pkg::NUM_VALID_USERS-1:0] valid_users,
    input  mbox_cfg_pkg::user_t                                     strap_root_user,
    output mbox_cfg_pkg::data_t                                     rdata,
    output logic                                                    rd_ack,
    output logic                                                    error,
    output logic                                                    hold,
    output logic                                                    soc_req_mbox_locked,
    output logic                                                    root_data_available,
    output logic                                                    soc_data_available,
    output logic                                                    sram_cs,
    output logic                                                    sram_we,
    output mbox_cfg_pkg::sram_addr_t                                sram_addr,
    output mbox_cfg_pkg::data_t                                     sram_wdata,
    input  mbox_cfg_pkg::data_t                                     sram_rdata
);

    import mbox_cfg_pkg::*;

    logic                  user_valid;
    logic                  user_is_root;
    logic                  user_is_holder;
    user_t                 holder;
    logic                  sram_req;
    logic                  sram_wr;
    logic [BUS_ADDR_W-1:0] sram_offset;
    data_t                 req_wdata;
    data_t                 sram_rdata_q;
    logic                  sram_rd_ack;
    logic                  ctrl_cs;
    logic                  ctrl_we;
    sram_addr_t            ctrl_addr;
    data_t                 ctrl_wdata;
    logic                  mbox_release;
    logic [SRAM_ADDR_W:0]  zero_words;
    logic                  zero_busy;
    logic                  zero_done;

    mbox_user_check i_user_check (
        .user(user), .valid_users(valid_users), .strap_root_user(strap_root_user),
        .holder(holder), .user_valid(user_valid), .user_is_root(user_is_root),
        .user_is_holder(user_is_holder)
    );

    mbox_regs i_regs (
        .clk(clk), .rst_b(rst_b), .req(req), .write(write), .addr(addr), .wdata(wdata),
        .user(user), .strap_root_user(strap_root_user), .user_valid(user_valid),
        .user_is_root(user_is_root), .user_is_holder(user_is_holder),
        .sram_rdata_q(sram_rdata_q), .sram_rd_ack(sram_rd_ack),
        .zero_busy(zero_busy), .zero_done(zero_done),
        .rdata(rdata), .rd_ack(rd_ack), .error(error), .hold(hold), .holder(holder),
        .sram_req(sram_req), .sram_wr(sram_wr), .sram_offset(sram_offset),
        .sram_wdata(req_wdata), .mbox_release(mbox_release), .zero_words(zero_words),
        .soc_req_mbox_locked(soc_req_mbox_locked),
        .root_data_available(root_data_available), .soc_data_available(soc_data_available)
    );

    mbox_sram_ctrl i_sram_ctrl (
        .clk(clk), .rst_b(rst_b), .sram_req(sram_req), .sram_wr(sram_wr),
        .sram_offset(sram_offset), .sram_wdata(req_wdata), .sram_rdata(sram_rdata),
        .cs(ctrl_cs), .we(ctrl_we), .addr(ctrl_addr), .wdata(ctrl_wdata),
        .sram_rdata_q(sram_rdata_q), .sram_rd_ack(sram_rd_ack)
    );

    mbox_zeroize i_zeroize (
        .clk(clk), .rst_b(rst_b), .mbox_release(mbox_release), .zero_words(zero_words),
        .cs_in(ctrl_cs), .we_in(ctrl_we), .addr_in(ctrl_addr), .wdata_in(ctrl_wdata),
        .sram_cs(sram_cs), .sram_we(sram_we), .sram_addr(sram_addr),
        .sram_wdata(sram_wdata), .zero_busy(zero_busy), .zero_done(zero_done)
    );

endmodule

/* dv/mbox_sram_model.sv */
// Behavioral single port SRAM for the mailbox testbench
// Word wide, one cycle read latency, preloaded with an address based pattern

`timescale 1ns/100ps

module mbox_sram_model (
    input  logic                     clk,
    input  logic                     cs,
    input  logic                     we,
    input  mbox_cfg_pkg::sram_addr_t addr,
    input  mbox_cfg_pkg::data_t      wdata,
    output mbox_cfg_pkg::data_t      rdata
);

    import mbox_cfg_pkg::*;

    data_t mem [SRAM_DEPTH];

    // Nonzero contents so cleared words stand out
    initial begin
        for (int i = 0; i < SRAM_DEPTH; i++) begin
            mem[i] = 32'hA5A5_0000 ^ data_t'(i);
        end
    end

    // Read data shows up the cycle after cs
    always @(posedge clk) begin
        if (cs && we) begin
            mem[addr] <= wdata;
        end else if (cs) begin
            rdata <= mem[addr];
        end
    end

endmodule

/* dv/mbox_tb.sv */
// Testbench for the mailbox controller
// Replays the steps of dv/mbox_tests.txt on the DUT backed by a behavioral SRAM

`timescale 1ns/100ps

module mbox_tb;

    import mbox_cfg_pkg::*;

    localparam user_t ROOT_USER = 32'hA000_0001;
    localparam int    CLK_HALF  = 5;

    logic                        clk;
    logic                        rst_b;
    logic                        req;
    logic                        write;
    logic [BUS_ADDR_W-1:0]       addr;
    data_t                       wdata;
    user_t                       user;
    user_t [NUM_VALID_USERS-1:0] valid_users;
    user_t                       strap_root_user;
    data_t                       rdata;
    logic                        rd_ack;
    logic                        error;
    logic                        hold;
    logic                        soc_req_mbox_locked;
    logic                        root_data_available;
    logic                        soc_data_available;
    logic                        sram_cs;
    logic                        sram_we;
    sram_addr_t                  sram_addr;
    data_t                       sram_wdata;
    data_t                       sram_rdata;

    // Test steps, one entry per line of the test file
    logic [8*16-1:0]       step_name [$];
    logic [8*4-1:0]        step_op [$];
    user_t                 step_user [$];
    logic [BUS_ADDR_W-1:0] step_addr [$];
    data_t                 step_data [$];
    data_t                 step_exp [$];

    // Request cycle view of lock request, hold and error
    logic [2:0] req_flags;
    logic       loaded = 1'b0;
    int         errors;
    int         test_errors;
    int         tests_passed;
    int         tests_failed;

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    mbox_top i_mbox_top (.*);

    mbox_sram_model i_sram_model (
        .clk(clk), .cs(sram_cs), .we(sram_we), .addr(sram_addr),
        .wdata(sram_wdata), .rdata(sram_rdata)
    );

    task automatic compare_values(input logic [8*16-1:0] name, input data_t expected,
                                  input data_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0s expected %h actual %h", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic flag_problem(input logic [8*16-1:0] name, input string what);
        $display("Test %0s: %0s", name, what);
        errors++;
        test_errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // Fabric access
    ////////////////////////////////////////////////////////////

    // One request cycle, then wait for rd_ack on reads
    task automatic bus_access(input logic is_wr, input user_t who,
                              input logic [BUS_ADDR_W-1:0] where, input data_t what,
                              output data_t got, output logic acked);
        int waited;
        waited = 0;
        got    = '0;
        acked  = 1'b1;
        req    = 1'b1;
        write  = is_wr;
        user   = who;
        addr   = where;
        wdata  = what;
        // Combinational flags have settled well before the rising edge
        #2;
        req_flags = {soc_req_mbox_locked, hold, error};
        @(negedge clk);
        req   = 1'b0;
        write = 1'b0;
        if (!is_wr) begin
            while (!rd_ack && waited < 4) begin
                @(negedge clk);
                waited++;
            end
            acked = rd_ack;
            got   = rdata;
        end
    endtask

    task automatic run_step(input int i);
        data_t got;
        logic  acked;
        logic  known;
        known = 1'b1;
        case (step_op[i])
            "rd": begin
                bus_access(1'b0, step_user[i], step_addr[i], '0, got, acked);
                if (!acked) begin
                    flag_problem(step_name[i],
                                 $sformatf("read at %h got no rd_ack", step_addr[i]));
                end else begin
                    compare_values(step_name[i], step_exp[i], got);
                end
            end
            "wr": bus_access(1'b1, step_user[i], step_addr[i], step_data[i], got, acked);
            "wt": repeat (step_data[i]) @(negedge clk);
            "ck": begin
                // Address column picks the output
                case (step_addr[i])
                    16'd0:   got = data_t'(req_flags[0]);
                    16'd1:   got = data_t'(req_flags[1]);
                    16'd2:   got = data_t'(req_flags[2]);
                    16'd3:   got = data_t'(root_data_available);
                    16'd4:   got = data_t'(soc_data_available);
                    default: known = 1'b0;
                endcase
                if (known) begin
                    compare_values(step_name[i], step_exp[i], got);
                end else begin
                    flag_problem(step_name[i], "unknown output selected for a check");
                end
            end
            default: flag_problem(step_name[i], "unknown operation in the test file");
        endcase
    endtask

    task automatic finish_test(input logic [8*16-1:0] name);
        if (test_errors == 0) begin
            $display("Test %0s passed", name);
            tests_passed++;
        end else begin
            $display("Test %0s failed with %0d bad checks", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // Test file
    ////////////////////////////////////////////////////////////

    task automatic load_tests();
        int                    fd;
        int                    cnt;
        logic [8*16-1:0]       name;
        logic [8*4-1:0]        op;
        logic [8*128-1:0]      rest;
        user_t                 u;
        logic [BUS_ADDR_W-1:0] a;
        data_t                 d;
        data_t                 e;
        fd = $fopen("dv/mbox_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file dv/mbox_tests.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", name) == 1) begin
                if (name == "#") begin
                    cnt = $fgets(rest, fd);
                end else begin
                    cnt = $fscanf(fd, "%s %h %h %h %h", op, u, a, d, e);
                    if (cnt != 5) begin
                        $display("Malformed line in the test file for %0s", name);
                        errors++;
                    end else begin
                        step_name.push_back(name);
                        step_op.push_back(op);
                        step_user.push_back(u);
                        step_addr.push_back(a);
                        step_data.push_back(d);
                        step_exp.push_back(e);
                    end
                end
            end
            $fclose(fd);
            if (step_name.size() == 0) begin
                $display("The test file holds no test steps");
                errors++;
            end
        end
    endtask

    initial begin
        rst_b           = 1'b0;
        req             = 1'b0;
        write           = 1'b0;
        addr            = '0;
        wdata           = '0;
        user            = '0;
        strap_root_user = ROOT_USER;
        for (int i = 0; i < NUM_VALID_USERS; i++) begin
            valid_users[i] = 32'h1000_0001 + i;
        end
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        load_tests();
        loaded = 1'b1;
        // Two rising edges in reset, released on a falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_b = 1'b1;
        compare_values("reset_pins", '0, data_t'({rd_ack, error, hold, sram_cs, sram_we}));
        // Root becomes holder on the first edge out of reset
        @(negedge clk);
        for (int i = 0; i < step_name.size(); i++) begin
            run_step(i);
            if (i == step_name.size() - 1 || step_name[i+1] != step_name[i]) begin
                finish_test(step_name[i]);
            end
        end
        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog sized from the number of test steps
    initial begin
        wait (loaded === 1'b1);
        repeat (20 * step_name.size() + SRAM_DEPTH) @(posedge clk);
        $display("Run timed out before the test steps finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* dv/mbox_tests.txt */
# name op user addr data expect, numbers in hex
# rd read, wr write, wt wait data cycles, ck output by addr 0 error 1 hold 2 lockreq 3 root 4 soc
reset_lock   rd A0000001 0004 0        A0000001
reset_lock   rd A0000001 0000 0        1
lock_request rd 10000001 0000 0        1
lock_request ck 0        2    0        1
lock_request rd A0000001 0004 0        A0000001
invalid_user wr 0BAD0000 0008 55       0
invalid_user ck 0        0    0        1
invalid_user rd A0000001 0008 0        0
invalid_user rd A0000001 0020 0        0
invalid_user ck 0        0    0        1
root_data    wr A0000001 0008 C        0
root_data    wr A0000001 2000 11111111 0
root_data    wr A0000001 2004 22222222 0
root_data    wr A0000001 2008 33333333 0
root_data    rd A0000001 2000 0        11111111
root_data    rd A0000001 2004 0        22222222
root_data    rd A0000001 2008 0        33333333
root_data    rd A0000001 3000 0        0
root_data    ck 0        1    0        1
release      wr A0000001 0010 1        0
release      ck 0        3    0        1
release      wr A0000001 0010 0        0
release      wt 0        0    5        0
release      rd 10000001 0000 0        0
release      rd 10000001 0004 0        10000001
release      rd 10000001 2000 0        0
release      rd 10000001 2004 0        0
release      rd 10000001 2008 0        0
soc_holder   wr 10000001 0008 8        0
soc_holder   wr 10000001 2010 CAFEF00D 0
soc_holder   wr 10000002 2010 DEADBEEF 0
soc_holder   rd 10000002 2010 0        0
soc_holder   rd 10000001 2010 0        CAFEF00D
soc_holder   wr 10000001 0010 1        0
soc_holder   ck 0        4    0        1

/* filelist.f */
hw/mbox_cfg_pkg.sv
hw/mbox_reg_pkg.sv
hw/mbox_user_check.sv
hw/mbox_regs.sv
hw/mbox_sram_ctrl.sv
hw/mbox_zeroize.sv
hw/mbox_top.sv
dv/mbox_sram_model.sv
dv/mbox_tb.sv

/* Bender.yml */
package:
  name: mbox_ctrl

sources:
  - hw/mbox_cfg_pkg.sv
  - hw/mbox_reg_pkg.sv
  - hw/mbox_user_check.sv
  - hw/mbox_regs.sv
  - hw/mbox_sram_ctrl.sv
  - hw/mbox_zeroize.sv
  - hw/mbox_top.sv
  - target: test
    files:
      - dv/mbox_sram_model.sv
      - dv/mbox_tb.sv
